//--- hdl/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [1:0]
    {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_t;

    typedef enum logic
    {
        OP2_RS2,
        OP2_IMM
    } op2_sel_t;

    typedef enum logic
    {
        RES_ALU,
        RES_LINK
    } res_src_t;

    typedef enum logic [2:0]
    {
        KIND_OP,
        KIND_OP_IMM,
        KIND_LUI,
        KIND_AUIPC,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_STORE
    } alu_kind_t;

    // the three groups are each one-hot, the two extra flags modify them
    typedef struct packed
    {
        logic arith_add;
        logic arith_sub;
        logic arith_shl;
        logic arith_shr;
        logic shift_arithmetical;
        logic bits_xor;
        logic bits_or;
        logic bits_and;
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;
    } alu_ctrl_t;

    typedef struct packed
    {
        logic arith;
        logic bits;
        logic shift;
        logic cmp;
    } alu_res_t;

    typedef struct packed
    {
        logic      valid;
        alu_kind_t kind;
        funct3_t   funct3;
        logic      funct7_5;
        op1_sel_t  op1_sel;
        op2_sel_t  op2_sel;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        word_t     pc;
        reg_addr_t rd;
        logic      reg_write;
        logic      compressed;
    } exec_in_t;

    typedef struct packed
    {
        logic      valid;
        word_t     op1;
        word_t     op2;
        alu_ctrl_t alu_ctrl;
        alu_res_t  alu_res;
        logic      store;
        logic      reg_write;
        reg_addr_t rd;
        logic      inst_jal_jalr;
        logic      inst_branch;
        word_t     pc;
        word_t     pc_target;
        res_src_t  res_src;
        funct3_t   funct3;
        word_t     reg_data2;
        logic      compressed;
    } alu1_bus_t;

    typedef struct packed
    {
        logic      valid;
        word_t     bits_result;
        word_t     shift_result;
        word_t     add;
        logic      cmp_result;
        logic      pc_select;
        alu_res_t  res;
        logic      store;
        logic      reg_write;
        reg_addr_t rd;
        word_t     pc_p4;
        word_t     pc_target;
        res_src_t  res_src;
        funct3_t   funct3;
        word_t     reg_data2;
    } alu2_bus_t;

    typedef struct packed
    {
        logic       valid;
        logic       reg_write;
        reg_addr_t  rd;
        word_t      wdata;
        logic       store;
        word_t      store_addr;
        word_t      store_data;
        logic [3:0] store_be;
    } exec_out_t;

    typedef struct packed
    {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

//--- hdl/rv_alu1.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu1
(
    input  wire                       i_clk,
    input  wire                       i_rst,
    input  wire rv_exec_pkg::exec_in_t i_instr,
    output rv_exec_pkg::alu1_bus_t    o_bus
);

    rv_exec_pkg::exec_in_t in_q;
    rv_exec_pkg::alu_res_t res;
    rv_exec_pkg::word_t    target_base;
    rv_exec_pkg::word_t    target_sum;
    logic [3:0]            arith_sel;
    logic [2:0]            bits_sel;
    logic [2:0]            cmp_sel;
    logic                  cmp_inv;
    logic                  shift_sra;
    logic                  is_branch;
    logic                  is_jump;
    logic                  is_store;

    always_ff @(posedge i_clk)
    begin
        in_q <= i_instr;
        if (i_rst)
        begin
            in_q.valid <= 1'b0;
        end
    end

    assign is_branch = (in_q.kind == rv_exec_pkg::KIND_BRANCH);
    assign is_store  = (in_q.kind == rv_exec_pkg::KIND_STORE);
    assign is_jump   = (in_q.kind == rv_exec_pkg::KIND_JAL) ||
                       (in_q.kind == rv_exec_pkg::KIND_JALR);

    // selector vectors are {add, sub, shl, shr}, {xor, or, and} and {eq, lts, ltu}
    always_comb
    begin
        arith_sel = 4'b1000;
        bits_sel  = 3'b001;
        cmp_sel   = 3'b100;
        cmp_inv   = 1'b0;
        shift_sra = 1'b0;
        res       = 4'b1000;
        if (in_q.kind == rv_exec_pkg::KIND_OP || in_q.kind == rv_exec_pkg::KIND_OP_IMM)
        begin
            case (in_q.funct3)
                3'b000:
                begin
                    if (in_q.kind == rv_exec_pkg::KIND_OP && in_q.funct7_5)
                    begin
                        arith_sel = 4'b0100;
                    end
                end
                3'b001:
                begin
                    arith_sel = 4'b0010;
                    res       = 4'b0010;
                end
                3'b010:
                begin
                    cmp_sel = 3'b010;
                    res     = 4'b0001;
                end
                3'b011:
                begin
                    cmp_sel = 3'b001;
                    res     = 4'b0001;
                end
                3'b100:
                begin
                    bits_sel = 3'b100;
                    res      = 4'b0100;
                end
                3'b101:
                begin
                    arith_sel = 4'b0001;
                    shift_sra = in_q.funct7_5;
                    res       = 4'b0010;
                end
                3'b110:
                begin
                    bits_sel = 3'b010;
                    res      = 4'b0100;
                end
                default:
                begin
                    res = 4'b0100;
                end
            endcase
        end
        else if (is_branch)
        begin
            // funct3 bit 0 turns beq/blt/bltu into bne/bge/bgeu
            cmp_sel = in_q.funct3[2] ? (in_q.funct3[1] ? 3'b001 : 3'b010) : 3'b100;
            cmp_inv = in_q.funct3[0];
            res     = 4'b0001;
        end
    end

    // jalr jumps from rs1, branches and jal from the pc
    assign target_base = (in_q.kind == rv_exec_pkg::KIND_JALR) ? in_q.rs1_data : in_q.pc;
    assign target_sum  = target_base + in_q.imm;

    always_comb
    begin
        o_bus.valid = in_q.valid;
        case (in_q.op1_sel)
            rv_exec_pkg::OP1_PC:   o_bus.op1 = in_q.pc;
            rv_exec_pkg::OP1_ZERO: o_bus.op1 = '0;
            default:               o_bus.op1 = in_q.rs1_data;
        endcase
        o_bus.op2 = (in_q.op2_sel == rv_exec_pkg::OP2_IMM) ? in_q.imm : in_q.rs2_data;
        if (is_branch)
        begin
            o_bus.op1 = in_q.rs1_data;
            o_bus.op2 = in_q.rs2_data;
        end
        o_bus.alu_ctrl      = {arith_sel, shift_sra, bits_sel, cmp_sel, cmp_inv};
        o_bus.alu_res       = res;
        o_bus.store         = is_store;
        o_bus.reg_write     = in_q.reg_write && (in_q.rd != '0) && !is_store && !is_branch;
        o_bus.rd            = in_q.rd;
        o_bus.inst_jal_jalr = is_jump;
        o_bus.inst_branch   = is_branch;
        o_bus.pc            = in_q.pc;
        o_bus.pc_target     = (in_q.kind == rv_exec_pkg::KIND_JALR) ?
                              {target_sum[31:1], 1'b0} : target_sum;
        o_bus.res_src       = is_jump ? rv_exec_pkg::RES_LINK : rv_exec_pkg::RES_ALU;
        o_bus.funct3        = in_q.funct3;
        o_bus.reg_data2     = in_q.rs2_data;
        o_bus.compressed    = in_q.compressed;
    end

    a_ctrl_onehot: assert property (@(posedge i_clk) disable iff (i_rst)
        o_bus.valid |->
            $onehot({o_bus.alu_ctrl.arith_add, o_bus.alu_ctrl.arith_sub,
                     o_bus.alu_ctrl.arith_shl, o_bus.alu_ctrl.arith_shr}) &&
            $onehot({o_bus.alu_ctrl.bits_xor, o_bus.alu_ctrl.bits_or,
                     o_bus.alu_ctrl.bits_and}) &&
            $onehot({o_bus.alu_ctrl.cmp_eq, o_bus.alu_ctrl.cmp_lts,
                     o_bus.alu_ctrl.cmp_ltu}) &&
            $onehot(o_bus.alu_res))
        else $error("alu1 control groups are not one-hot");

endmodule

`default_nettype wire

//--- hdl/rv_alu2.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu2
#(
    parameter bit P_EXT_C = 1'b1
)
(
    input  wire                        i_clk,
    input  wire                        i_rst,
    input  wire rv_exec_pkg::alu1_bus_t i_bus,
    output rv_exec_pkg::alu2_bus_t     o_bus
);

    rv_exec_pkg::alu1_bus_t bus_q;
    rv_exec_pkg::word_t     op_b;
    rv_exec_pkg::word_t     shl;
    rv_exec_pkg::word_t     srl;
    rv_exec_pkg::word_t     sra;
    rv_exec_pkg::word_t     bits_result;
    rv_exec_pkg::word_t     shift_result;
    rv_exec_pkg::word_t     pc_p4;
    logic [32:0]            add;
    logic                   op_b_sel;
    logic                   negative;
    logic                   overflow;
    logic                   carry;
    logic                   eq;
    logic                   lts;
    logic                   ltu;
    logic                   cmp_result;
    logic                   pc_select;

    always_ff @(posedge i_clk)
    begin
        bus_q <= i_bus;
        if (i_rst)
        begin
            bus_q.valid <= 1'b0;
        end
    end

    // one adder serves add, sub and all compares, which subtract op2
    assign op_b_sel = bus_q.alu_ctrl.arith_sub | bus_q.alu_res.cmp;
    assign op_b     = op_b_sel ? ~bus_q.op2 : bus_q.op2;
    assign add      = {1'b0, bus_q.op1} + {1'b0, op_b} + 33'(op_b_sel);
    assign negative = add[31];
    assign overflow = (bus_q.op1[31] ^ bus_q.op2[31]) & (bus_q.op1[31] ^ add[31]);
    assign carry    = add[32];

    assign eq  = bus_q.alu_ctrl.cmp_inversed ^ (bus_q.op1 == bus_q.op2);
    assign lts = bus_q.alu_ctrl.cmp_inversed ^ (negative ^ overflow);
    // no carry out of op1 + ~op2 + 1 means op1 < op2 unsigned
    assign ltu = bus_q.alu_ctrl.cmp_inversed ^ !carry;

    assign shl = bus_q.op1 << bus_q.op2[4:0];
    assign srl = bus_q.op1 >> bus_q.op2[4:0];
    assign sra = $signed(bus_q.op1) >>> bus_q.op2[4:0];

    always_comb
    begin
        case (1'b1)
            bus_q.alu_ctrl.cmp_lts: cmp_result = lts;
            bus_q.alu_ctrl.cmp_ltu: cmp_result = ltu;
            default:                cmp_result = eq;
        endcase
    end

    always_comb
    begin
        case (1'b1)
            bus_q.alu_ctrl.bits_xor: bits_result = bus_q.op1 ^ bus_q.op2;
            bus_q.alu_ctrl.bits_or:  bits_result = bus_q.op1 | bus_q.op2;
            default:                 bits_result = bus_q.op1 & bus_q.op2;
        endcase
    end

    always_comb
    begin
        if (bus_q.alu_ctrl.arith_shr)
        begin
            shift_result = bus_q.alu_ctrl.shift_arithmetical ? sra : srl;
        end
        else
        begin
            shift_result = shl;
        end
    end

    assign pc_select = bus_q.inst_jal_jalr | (bus_q.inst_branch & cmp_result);

    // compressed instructions link to the next halfword
    assign pc_p4 = bus_q.pc + ((P_EXT_C && bus_q.compressed) ? 32'd2 : 32'd4);

    assign o_bus.valid        = bus_q.valid;
    assign o_bus.bits_result  = bits_result;
    assign o_bus.shift_result = shift_result;
    assign o_bus.add          = add[31:0];
    assign o_bus.cmp_result   = cmp_result;
    assign o_bus.pc_select    = pc_select;
    assign o_bus.res          = bus_q.alu_res;
    assign o_bus.store        = bus_q.store;
    assign o_bus.reg_write    = bus_q.reg_write;
    assign o_bus.rd           = bus_q.rd;
    assign o_bus.pc_p4        = pc_p4;
    assign o_bus.pc_target    = bus_q.pc_target;
    assign o_bus.res_src      = bus_q.res_src;
    assign o_bus.funct3       = bus_q.funct3;
    assign o_bus.reg_data2    = bus_q.reg_data2;

    a_no_stray_select: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_bus.valid && o_bus.pc_select) |->
            ((o_bus.res_src == rv_exec_pkg::RES_LINK) || o_bus.res.cmp))
        else $error("pc_select raised by a non control-transfer instruction");

endmodule

`default_nettype wire

//--- hdl/rv_alu3.sv
`timescale 1ns/1ps
`default_nettype none

module rv_alu3
#(
    parameter bit P_EXT_C = 1'b1
)
(
    input  wire                        i_clk,
    input  wire                        i_rst,
    input  wire rv_exec_pkg::alu2_bus_t i_bus,
    output rv_exec_pkg::exec_out_t     o_result,
    output rv_exec_pkg::redirect_t     o_redirect
);

    rv_exec_pkg::alu2_bus_t bus_q;
    rv_exec_pkg::word_t     alu_value;
    rv_exec_pkg::word_t     st_data;
    logic [3:0]             st_be;
    logic                   st;

    always_ff @(posedge i_clk)
    begin
        bus_q <= i_bus;
        if (i_rst)
        begin
            bus_q.valid <= 1'b0;
        end
    end

    always_comb
    begin
        case (1'b1)
            bus_q.res.arith: alu_value = bus_q.add;
            bus_q.res.bits:  alu_value = bus_q.bits_result;
            bus_q.res.shift: alu_value = bus_q.shift_result;
            default:         alu_value = 32'(bus_q.cmp_result);
        endcase
    end

    // narrow stores repeat their data on every lane and enable only the addressed ones
    always_comb
    begin
        case (bus_q.funct3)
            3'b000:
            begin
                st_data = {4{bus_q.reg_data2[7:0]}};
                st_be   = 4'b0001 << bus_q.add[1:0];
            end
            3'b001:
            begin
                st_data = {2{bus_q.reg_data2[15:0]}};
                st_be   = bus_q.add[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                st_data = bus_q.reg_data2;
                st_be   = 4'b1111;
            end
        endcase
    end

    assign st = bus_q.valid & bus_q.store;

    assign o_result.valid      = bus_q.valid;
    assign o_result.reg_write  = bus_q.valid & bus_q.reg_write;
    assign o_result.rd         = bus_q.rd;
    assign o_result.wdata      = (bus_q.res_src == rv_exec_pkg::RES_LINK) ?
                                 bus_q.pc_p4 : alu_value;
    assign o_result.store      = st;
    assign o_result.store_addr = st ? bus_q.add : '0;
    assign o_result.store_data = st ? st_data : '0;
    assign o_result.store_be   = st ? st_be : 4'b0000;

    assign o_redirect.valid  = bus_q.valid & bus_q.pc_select;
    assign o_redirect.target = bus_q.pc_target;

    a_target_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        o_redirect.valid |->
            (P_EXT_C ? (o_redirect.target[0] == 1'b0) : (o_redirect.target[1:0] == 2'b00)))
        else $error("redirect target is misaligned");

endmodule

`default_nettype wire

//--- hdl/rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top
#(
    parameter bit P_EXT_C = 1'b1
)
(
    input  wire                        i_clk,
    input  wire                        i_rst,
    input  wire rv_exec_pkg::exec_in_t i_instr,
    output rv_exec_pkg::exec_out_t     o_result,
    output rv_exec_pkg::redirect_t     o_redirect
);

    rv_exec_pkg::alu1_bus_t alu1_bus;
    rv_exec_pkg::alu2_bus_t alu2_bus;

    rv_alu1 alu1
    (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_instr (i_instr),
        .o_bus   (alu1_bus)
    );

    rv_alu2 #(.P_EXT_C(P_EXT_C)) alu2
    (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_bus (alu1_bus),
        .o_bus (alu2_bus)
    );

    rv_alu3 #(.P_EXT_C(P_EXT_C)) alu3
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_bus      (alu2_bus),
        .o_result   (o_result),
        .o_redirect (o_redirect)
    );

endmodule

`default_nettype wire

//--- include/tb_rv_exec_ref.svh
`ifndef TB_RV_EXEC_REF_SVH
`define TB_RV_EXEC_REF_SVH

function automatic logic ref_taken(input rv_exec_pkg::exec_in_t ins);
    logic taken;
    case (ins.funct3)
        3'b001:  taken = ins.rs1_data != ins.rs2_data;
        3'b100:  taken = $signed(ins.rs1_data) < $signed(ins.rs2_data);
        3'b101:  taken = $signed(ins.rs1_data) >= $signed(ins.rs2_data);
        3'b110:  taken = ins.rs1_data < ins.rs2_data;
        3'b111:  taken = ins.rs1_data >= ins.rs2_data;
        default: taken = ins.rs1_data == ins.rs2_data;
    endcase
    return taken;
endfunction

// value the ALU path reports, before the link address is considered
function automatic rv_exec_pkg::word_t ref_alu(input rv_exec_pkg::exec_in_t ins);
    rv_exec_pkg::word_t a;
    rv_exec_pkg::word_t b;
    rv_exec_pkg::word_t value;
    a = ins.rs1_data;
    b = (ins.kind == rv_exec_pkg::KIND_OP) ? ins.rs2_data : ins.imm;
    case (ins.kind)
        rv_exec_pkg::KIND_OP, rv_exec_pkg::KIND_OP_IMM:
        begin
            case (ins.funct3)
                3'b000:
                begin
                    value = (ins.kind == rv_exec_pkg::KIND_OP && ins.funct7_5) ? a - b : a + b;
                end
                3'b001: value = a << b[4:0];
                3'b010: value = {31'b0, $signed(a) < $signed(b)};
                3'b011: value = {31'b0, a < b};
                3'b100: value = a ^ b;
                3'b101:
                begin
                    if (ins.funct7_5)
                    begin
                        value = $signed(a) >>> b[4:0];
                    end
                    else
                    begin
                        value = a >> b[4:0];
                    end
                end
                3'b110: value = a | b;
                default: value = a & b;
            endcase
        end
        rv_exec_pkg::KIND_LUI:    value = ins.imm;
        rv_exec_pkg::KIND_AUIPC:  value = ins.pc + ins.imm;
        rv_exec_pkg::KIND_BRANCH: value = {31'b0, ref_taken(ins)};
        default:                  value = a + ins.imm;
    endcase
    return value;
endfunction

function automatic rv_exec_pkg::exec_out_t ref_result(input rv_exec_pkg::exec_in_t ins,
                                                      input bit ext_c);
    rv_exec_pkg::exec_out_t r;
    rv_exec_pkg::word_t     addr;
    logic                   jump;
    r     = '0;
    jump  = (ins.kind == rv_exec_pkg::KIND_JAL) || (ins.kind == rv_exec_pkg::KIND_JALR);
    addr  = ins.rs1_data + ins.imm;
    r.valid = ins.valid;
    r.rd    = ins.rd;
    r.wdata = jump ? ins.pc + ((ext_c && ins.compressed) ? 32'd2 : 32'd4) : ref_alu(ins);
    r.reg_write = ins.valid && ins.reg_write && (ins.rd != '0) &&
                  (ins.kind != rv_exec_pkg::KIND_STORE) && (ins.kind != rv_exec_pkg::KIND_BRANCH);
    r.store = ins.valid && (ins.kind == rv_exec_pkg::KIND_STORE);
    if (r.store)
    begin
        r.store_addr = addr;
        case (ins.funct3)
            3'b000:
            begin
                r.store_data = {4{ins.rs2_data[7:0]}};
                r.store_be   = 4'b0001 << addr[1:0];
            end
            3'b001:
            begin
                r.store_data = {2{ins.rs2_data[15:0]}};
                r.store_be   = addr[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                r.store_data = ins.rs2_data;
                r.store_be   = 4'b1111;
            end
        endcase
    end
    return r;
endfunction

function automatic rv_exec_pkg::redirect_t ref_redirect(input rv_exec_pkg::exec_in_t ins);
    rv_exec_pkg::redirect_t r;
    rv_exec_pkg::word_t     sum;
    sum = ins.rs1_data + ins.imm;
    r.valid = ins.valid && ((ins.kind == rv_exec_pkg::KIND_JAL) ||
                            (ins.kind == rv_exec_pkg::KIND_JALR) ||
                            ((ins.kind == rv_exec_pkg::KIND_BRANCH) && ref_taken(ins)));
    r.target = (ins.kind == rv_exec_pkg::KIND_JALR) ? {sum[31:1], 1'b0} : ins.pc + ins.imm;
    return r;
endfunction

`endif

//--- verification/tb_rv_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec;

    localparam logic [31:0] SEED = 32'hc14bce03;

    logic                   i_clk;
    logic                   i_rst;
    rv_exec_pkg::exec_in_t  i_instr;
    rv_exec_pkg::exec_out_t o_result;
    rv_exec_pkg::redirect_t o_redirect;

    // expected outputs with the cycle count at which they must be visible
    rv_exec_pkg::exec_out_t exp_res [$];
    rv_exec_pkg::redirect_t exp_red [$];
    int unsigned            exp_due [$];
    rv_exec_pkg::exec_out_t head_res;
    rv_exec_pkg::redirect_t head_red;
    int unsigned            cycle_count = 0;
    string                  test_name;

    `include "tb_rv_exec_ref.svh"

    rv_exec_top #(.P_EXT_C(1'b1)) dut0
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_instr    (i_instr),
        .o_result   (o_result),
        .o_redirect (o_redirect)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        cycle_count <= cycle_count + 1;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    function automatic rv_exec_pkg::word_t rnd();
        return $urandom();
    endfunction

    function automatic rv_exec_pkg::word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // operand selections follow what the decoder would produce for each kind
    function automatic rv_exec_pkg::exec_in_t make_instr(input rv_exec_pkg::alu_kind_t kind,
                                                         input rv_exec_pkg::funct3_t f3,
                                                         input logic f7,
                                                         input rv_exec_pkg::word_t rs1,
                                                         input rv_exec_pkg::word_t rs2,
                                                         input rv_exec_pkg::word_t imm,
                                                         input rv_exec_pkg::word_t pc,
                                                         input logic compressed);
        rv_exec_pkg::exec_in_t ins;
        rv_exec_pkg::word_t    r;
        r              = rnd();
        ins            = '0;
        ins.valid      = 1'b1;
        ins.kind       = kind;
        ins.funct3     = f3;
        ins.funct7_5   = f7;
        ins.op1_sel    = rv_exec_pkg::OP1_RS1;
        ins.op2_sel    = rv_exec_pkg::OP2_IMM;
        if (kind == rv_exec_pkg::KIND_AUIPC)
        begin
            ins.op1_sel = rv_exec_pkg::OP1_PC;
        end
        else if (kind == rv_exec_pkg::KIND_LUI)
        begin
            ins.op1_sel = rv_exec_pkg::OP1_ZERO;
        end
        if (kind == rv_exec_pkg::KIND_OP || kind == rv_exec_pkg::KIND_BRANCH)
        begin
            ins.op2_sel = rv_exec_pkg::OP2_RS2;
        end
        ins.rs1_data   = rs1;
        ins.rs2_data   = rs2;
        ins.imm        = imm;
        ins.pc         = pc;
        ins.rd         = r[4:0];
        ins.reg_write  = 1'b1;
        ins.compressed = compressed;
        return ins;
    endfunction

    task automatic issue(input rv_exec_pkg::exec_in_t ins);
        @(posedge i_clk);
        #1;
        i_instr = ins;
        // sampled at the next edge, visible after two more
        exp_res.push_back(ref_result(ins, 1'b1));
        exp_red.push_back(ref_redirect(ins));
        exp_due.push_back(cycle_count + 3);
    endtask

    task automatic idle();
        @(posedge i_clk);
        #1;
        i_instr = '0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_due.size() > 0)
        begin
            idle();
            waited++;
            if (waited > 10)
            begin
                abort_run($sformatf("%s: pipeline did not drain within 10 cycles", test_name));
            end
        end
    endtask

    // outputs change only at rising edges, so the falling edge sees them settled
    always @(negedge i_clk)
    begin
        if (cycle_count >= 1)
        begin
            if (exp_due.size() > 0 && exp_due[0] == cycle_count)
            begin
                head_res = exp_res.pop_front();
                head_red = exp_red.pop_front();
                void'(exp_due.pop_front());
                assert (o_result == head_res)
                else abort_run($sformatf("CHECK FAILED %s: result expected %h actual %h",
                                         test_name, head_res, o_result));
                assert (o_redirect.valid == head_red.valid &&
                        (!head_red.valid || o_redirect.target == head_red.target))
                else abort_run($sformatf("CHECK FAILED %s: redirect expected %h actual %h",
                                         test_name, head_red, o_redirect));
            end
            else
            begin
                assert (!o_result.valid && !o_redirect.valid)
                else abort_run($sformatf("%s: an output became valid with nothing due",
                                         test_name));
            end
        end
    end

    task automatic reset_and_bubbles();
        test_name = "reset_and_bubbles";
        repeat (4) idle();
        issue(make_instr(rv_exec_pkg::KIND_OP, 3'b000, 1'b0, rnd(), rnd(), '0, '0, 1'b0));
        drain();
    endtask

    task automatic arith_logic();
        rv_exec_pkg::alu_kind_t kind;
        rv_exec_pkg::funct3_t   f3;
        logic                   f7;
        test_name = "arith_logic";
        for (int i = 0; i < 20; i++)
        begin
            f7 = 1'b0;
            case (i % 5)
                0: f3 = 3'b000;
                1:
                begin
                    f3 = 3'b000;
                    f7 = 1'b1;
                end
                2: f3 = 3'b100;
                3: f3 = 3'b110;
                default: f3 = 3'b111;
            endcase
            if (i < 10)
            begin
                kind = rv_exec_pkg::KIND_OP;
            end
            else
            begin
                kind = rv_exec_pkg::KIND_OP_IMM;
            end
            issue(make_instr(kind, f3, f7, rnd(), rnd(), sext12(12'(rnd())), '0, 1'b0));
        end
        drain();
    endtask

    task automatic shifts_and_slt();
        rv_exec_pkg::alu_kind_t kind;
        rv_exec_pkg::word_t     rs1;
        rv_exec_pkg::word_t     pa [6];
        rv_exec_pkg::word_t     pb [6];
        test_name = "shifts_and_slt";
        for (int i = 0; i < 12; i++)
        begin
            rs1 = rnd();
            if (i[0])
            begin
                rs1[31] = 1'b1;
            end
            if (i < 6)
            begin
                kind = rv_exec_pkg::KIND_OP;
            end
            else
            begin
                kind = rv_exec_pkg::KIND_OP_IMM;
            end
            case (i % 3)
                0: issue(make_instr(kind, 3'b001, 1'b0, rs1, rnd(), rnd(), '0, 1'b0));
                1: issue(make_instr(kind, 3'b101, 1'b0, rs1, rnd(), rnd(), '0, 1'b0));
                default: issue(make_instr(kind, 3'b101, 1'b1, rs1, rnd(), rnd(), '0, 1'b0));
            endcase
        end
        pa = '{32'h7fffffff, 32'h80000000, 32'hffffffff, 32'h00000000, 32'h80000000, 32'h1};
        pb = '{32'h80000000, 32'h7fffffff, 32'h00000000, 32'hffffffff, 32'h80000000, 32'h0};
        for (int p = 0; p < 6; p++)
        begin
            issue(make_instr(rv_exec_pkg::KIND_OP, 3'b010, 1'b0, pa[p], pb[p], '0, '0, 1'b0));
            issue(make_instr(rv_exec_pkg::KIND_OP, 3'b011, 1'b0, pa[p], pb[p], '0, '0, 1'b0));
        end
        drain();
    endtask

    task automatic branches();
        rv_exec_pkg::word_t pa [5];
        rv_exec_pkg::word_t pb [5];
        rv_exec_pkg::word_t r;
        test_name = "branches";
        pa = '{32'h00001234, 32'h00000005, 32'h00000009, 32'hfffffff0, 32'h00000010};
        pb = '{32'h00001234, 32'h00000009, 32'h00000005, 32'h00000010, 32'hfffffff0};
        for (int f = 0; f < 8; f++)
        begin
            if (f != 2 && f != 3)
            begin
                for (int p = 0; p < 5; p++)
                begin
                    r = rnd();
                    issue(make_instr(rv_exec_pkg::KIND_BRANCH, f[2:0], 1'b0, pa[p], pb[p],
                                     sext12({r[11:1], 1'b0}), {r[31:2], 2'b00}, 1'b0));
                end
            end
        end
        drain();
    endtask

    task automatic jumps_and_upper();
        rv_exec_pkg::word_t r;
        rv_exec_pkg::word_t pc;
        test_name = "jumps_and_upper";
        for (int i = 0; i < 4; i++)
        begin
            r  = rnd();
            pc = {r[31:2], 2'b00};
            issue(make_instr(rv_exec_pkg::KIND_JAL, 3'b000, 1'b0, rnd(), rnd(),
                             sext12({r[11:1], 1'b0}), pc, i[0]));
            issue(make_instr(rv_exec_pkg::KIND_JALR, 3'b000, 1'b0, rnd(), rnd(),
                             sext12(r[13:2]), pc, i[1]));
            issue(make_instr(rv_exec_pkg::KIND_LUI, 3'b000, 1'b0, rnd(), rnd(),
                             {r[31:12], 12'h000}, pc, 1'b0));
            issue(make_instr(rv_exec_pkg::KIND_AUIPC, 3'b000, 1'b0, rnd(), rnd(),
                             {r[23:4], 12'h000}, pc, 1'b0));
        end
        drain();
    endtask

    task automatic stores();
        rv_exec_pkg::word_t r;
        test_name = "stores";
        for (int f = 0; f < 3; f++)
        begin
            for (int k = 0; k < 4; k++)
            begin
                r = rnd();
                issue(make_instr(rv_exec_pkg::KIND_STORE, f[2:0], 1'b0, {r[31:2], 2'b00},
                                 rnd(), sext12({r[13:4], k[1:0]}), '0, 1'b0));
            end
        end
        drain();
    endtask

    initial
    begin
        void'($urandom(SEED));
        i_rst     = 1'b1;
        i_instr   = '0;
        test_name = "reset";
        repeat (3) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        reset_and_bubbles();
        arith_logic();
        shifts_and_slt();
        branches();
        jumps_and_upper();
        stores();
        repeat (2) idle();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
hdl/rv_exec_pkg.sv
hdl/rv_alu1.sv
hdl/rv_alu2.sv
hdl/rv_alu3.sv
hdl/rv_exec_top.sv
verification/tb_rv_exec.sv

//--- run_sim.sh
#!/bin/sh
# builds the execute-stage testbench with Verilator and runs it
# the exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_rv_exec \
    -f all.f \
    -o tb_rv_exec
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_rv_exec
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0
